// File: src/noc_flit_pkg.sv
package noc_flit_pkg;

    // Link side flit format
    localparam int FLIT_W = 16;
    localparam int DEST_W = 3;

    typedef logic [FLIT_W-1:0] flit_data_t;
    typedef logic [DEST_W-1:0] dest_t;

    typedef struct packed {
        flit_data_t data;
        dest_t      dest;
        logic       is_tail;
    } flit_t;

    // Upper bound on the credits a far receiver may advertise
    localparam int MAX_CREDITS = 15;

    typedef logic [$clog2(MAX_CREDITS + 1)-1:0] credit_count_t;

endpackage: noc_flit_pkg

// File: src/noc_axis_pkg.sv
package noc_axis_pkg;

    // Flits per user beat
    localparam int SER_FACTOR = 4;

    localparam int BEAT_W = noc_flit_pkg::FLIT_W * SER_FACTOR;

    typedef logic [BEAT_W-1:0] beat_data_t;

    // Position of a flit inside its beat
    typedef logic [$clog2(SER_FACTOR)-1:0] ser_index_t;

    typedef struct packed {
        beat_data_t          data;
        noc_flit_pkg::dest_t dest;
        logic                last;
    } axis_beat_t;

endpackage: noc_axis_pkg

// File: src/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       wr_en,
    input  wire noc_flit_pkg::flit_t  wr_flit,
    input  wire                       rd_en,
    output noc_flit_pkg::flit_t       rd_flit,
    output logic                      empty,
    output logic                      full
);
    import noc_flit_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;
    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));

    // Head entry is always shown ahead on the output
    assign rd_flit = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + CNT_W'(1);
            end else if (do_rd && !do_wr) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule: flit_fifo

// File: src/axis_serializer.sv
`timescale 1ns/1ps

module axis_serializer (
    input  wire                            clk,
    input  wire                            rst_n,

    input  wire                            src_valid,
    output logic                           src_ready,
    input  wire noc_axis_pkg::axis_beat_t  src_beat,

    output logic                           flit_valid,
    input  wire                            flit_ready,
    output noc_flit_pkg::flit_t            flit
);
    import noc_flit_pkg::*;
    import noc_axis_pkg::*;

    localparam ser_index_t LAST_IDX = ser_index_t'(SER_FACTOR - 1);

    axis_beat_t beat_q;
    ser_index_t idx;
    logic       busy;
    logic       take;
    logic       accept;

    assign take = busy && flit_ready;
    assign accept = src_valid && src_ready;

    // Next beat may enter while the final flit of the current one leaves
    assign src_ready = !busy || (take && idx == LAST_IDX);
    assign flit_valid = busy;

    // Lowest slice goes out first
    always_comb begin
        flit.data = beat_q.data[idx * FLIT_W +: FLIT_W];
        flit.dest = beat_q.dest;
        flit.is_tail = beat_q.last && (idx == LAST_IDX);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx <= '0;
        end else begin
            if (take) begin
                idx <= (idx == LAST_IDX) ? '0 : idx + ser_index_t'(1);
            end
            if (accept) begin
                busy <= 1'b1;
            end else if (take && idx == LAST_IDX) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= src_beat;
        end
    end

endmodule: axis_serializer

// File: src/flit_injector.sv
`timescale 1ns/1ps

module flit_injector #(
    parameter int CREDITS  = 4,
    parameter int TX_DEPTH = 4
) (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       flit_valid,
    output logic                      flit_ready,
    input  wire noc_flit_pkg::flit_t  flit,

    output noc_flit_pkg::flit_t       tx_flit,
    output logic                      tx_send,
    input  wire                       tx_credit
);
    import noc_flit_pkg::*;

    flit_t         head_flit;
    logic          buf_empty;
    logic          buf_full;
    logic          rd_en;
    credit_count_t credit_count;

    assign flit_ready = !buf_full;

    // Only pull a flit when the far end has room for it
    assign rd_en = !buf_empty && (credit_count != '0);

    flit_fifo #(
        .DEPTH  (TX_DEPTH)
    ) tx_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (flit_valid && flit_ready),
        .wr_flit (flit),
        .rd_en   (rd_en),
        .rd_flit (head_flit),
        .empty   (buf_empty),
        .full    (buf_full)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_count <= credit_count_t'(CREDITS);
            tx_send <= 1'b0;
        end else begin
            credit_count <= credit_count + credit_count_t'(tx_credit)
                            - credit_count_t'(rd_en);
            tx_send <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            tx_flit <= head_flit;
        end
    end

endmodule: flit_injector

// File: src/flit_ejector.sv
`timescale 1ns/1ps

module flit_ejector #(
    parameter int CREDITS = 4
) (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire noc_flit_pkg::flit_t  rx_flit,
    input  wire                       rx_send,
    output logic                      rx_credit,

    output logic                      flit_valid,
    input  wire                       flit_ready,
    output noc_flit_pkg::flit_t       flit
);
    logic buf_empty;
    logic pop;

    assign flit_valid = !buf_empty;
    assign pop = flit_valid && flit_ready;

    // Each slot freed goes straight back to the sender
    assign rx_credit = pop;

    // One slot per credit, so the sender can never overrun it
    flit_fifo #(
        .DEPTH  (CREDITS)
    ) rx_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (rx_send),
        .wr_flit (rx_flit),
        .rd_en   (pop),
        .rd_flit (flit),
        .empty   (buf_empty),
        .full    ()
    );

endmodule: flit_ejector

// File: src/axis_deserializer.sv
`timescale 1ns/1ps

module axis_deserializer (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       flit_valid,
    output logic                      flit_ready,
    input  wire noc_flit_pkg::flit_t  flit,

    output logic                      snk_valid,
    input  wire                       snk_ready,
    output noc_axis_pkg::axis_beat_t  snk_beat
);
    import noc_flit_pkg::*;
    import noc_axis_pkg::*;

    localparam ser_index_t LAST_IDX = ser_index_t'(SER_FACTOR - 1);

    axis_beat_t beat_q;
    ser_index_t idx;
    logic       take;

    // A held beat blocks new flits unless it leaves this cycle
    assign flit_ready = !snk_valid || snk_ready;
    assign take = flit_valid && flit_ready;
    assign snk_beat = beat_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
            snk_valid <= 1'b0;
        end else begin
            if (take) begin
                idx <= (idx == LAST_IDX) ? '0 : idx + ser_index_t'(1);
            end
            if (take && idx == LAST_IDX) begin
                snk_valid <= 1'b1;
            end else if (snk_ready) begin
                snk_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            beat_q.data[idx * FLIT_W +: FLIT_W] <= flit.data;
            // Destination and tail come with the final flit
            if (idx == LAST_IDX) begin
                beat_q.dest <= flit.dest;
                beat_q.last <= flit.is_tail;
            end
        end
    end

endmodule: axis_deserializer

// File: src/noc_axis_endpoint.sv
`timescale 1ns/1ps

module noc_axis_endpoint #(
    parameter int CREDITS  = 4,
    parameter int TX_DEPTH = 4
) (
    input  wire                            clk,
    input  wire                            rst_n,

    input  wire                            src_valid,
    output logic                           src_ready,
    input  wire noc_axis_pkg::axis_beat_t  src_beat,

    output logic                           snk_valid,
    input  wire                            snk_ready,
    output noc_axis_pkg::axis_beat_t       snk_beat,

    output noc_flit_pkg::flit_t            tx_flit,
    output logic                           tx_send,
    input  wire                            tx_credit,

    input  wire noc_flit_pkg::flit_t       rx_flit,
    input  wire                            rx_send,
    output logic                           rx_credit
);
    import noc_flit_pkg::*;

    flit_t ser_flit;
    logic  ser_flit_valid;
    logic  ser_flit_ready;
    flit_t ej_flit;
    logic  ej_flit_valid;
    logic  ej_flit_ready;

    // Transmit path
    axis_serializer serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src_beat   (src_beat),
        .flit_valid (ser_flit_valid),
        .flit_ready (ser_flit_ready),
        .flit       (ser_flit)
    );

    flit_injector #(
        .CREDITS    (CREDITS),
        .TX_DEPTH   (TX_DEPTH)
    ) injector (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_valid (ser_flit_valid),
        .flit_ready (ser_flit_ready),
        .flit       (ser_flit),
        .tx_flit    (tx_flit),
        .tx_send    (tx_send),
        .tx_credit  (tx_credit)
    );

    // Receive path
    flit_ejector #(
        .CREDITS    (CREDITS)
    ) ejector (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_flit    (rx_flit),
        .rx_send    (rx_send),
        .rx_credit  (rx_credit),
        .flit_valid (ej_flit_valid),
        .flit_ready (ej_flit_ready),
        .flit       (ej_flit)
    );

    axis_deserializer deserializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_valid (ej_flit_valid),
        .flit_ready (ej_flit_ready),
        .flit       (ej_flit),
        .snk_valid  (snk_valid),
        .snk_ready  (snk_ready),
        .snk_beat   (snk_beat)
    );

endmodule: noc_axis_endpoint

// File: tests/noc_axis_endpoint_sva.sv
`timescale 1ns/1ps

module flit_injector_sva #(
    parameter int CREDITS = 4
) (
    input wire                               clk,
    input wire                               rst_n,
    input wire noc_flit_pkg::credit_count_t  credit_count,
    input wire                               tx_send
);
    import noc_flit_pkg::*;

    int fail_count = 0;

    credit_ceiling: assert property (@(posedge clk) disable iff (!rst_n)
        credit_count <= credit_count_t'(CREDITS))
        else begin
            $error("injector credit count above the advertised credits");
            fail_count++;
        end

    // A send spends a credit, so none may follow a cycle with the counter at zero
    no_send_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
        tx_send |-> $past(credit_count) != '0)
        else begin
            $error("injector sent a flit with no credit left");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !tx_send)
        else begin
            $error("tx_send high in the cycle after reset");
            fail_count++;
        end

endmodule: flit_injector_sva

bind flit_injector flit_injector_sva #(
    .CREDITS      (CREDITS)
) assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .credit_count (credit_count),
    .tx_send      (tx_send)
);

// File: tests/noc_axis_endpoint_tb.sv
`timescale 1ns/1ps

module noc_axis_endpoint_tb;
    import noc_flit_pkg::*;
    import noc_axis_pkg::*;

    localparam int CREDITS = 4;
    localparam int NUM_BEATS = 12;
    localparam int TIMEOUT = 400;

    typedef struct packed {
        axis_beat_t beat;
        int         sink_stall;
        int         credit_hold;
    } stim_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       src_valid;
    logic       src_ready;
    axis_beat_t src_beat;
    logic       snk_valid;
    logic       snk_ready;
    axis_beat_t snk_beat;
    flit_t      tx_flit;
    logic       tx_send;
    logic       tx_credit;
    logic       rx_credit;

    stim_t stim [NUM_BEATS];
    flit_t exp_flits [NUM_BEATS * SER_FACTOR];
    int    flit_count = 0;
    int    beat_count = 0;
    int    outstanding = 0;
    int    max_outstanding = 0;
    int    pend = 0;
    int    stall_left = 0;
    int    hold_left = 0;
    int    low_run = 0;
    logic  fired;
    logic  src_stalled = 1'b0;

    always #5 clk = ~clk;

    noc_axis_endpoint #(
        .CREDITS   (CREDITS),
        .TX_DEPTH  (4)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src_beat  (src_beat),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready),
        .snk_beat  (snk_beat),
        .tx_flit   (tx_flit),
        .tx_send   (tx_send),
        .tx_credit (tx_credit),
        .rx_flit   (tx_flit),
        .rx_send   (tx_send),
        .rx_credit (rx_credit)
    );

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("Timed out waiting for %s", what);
        report_failure();
    endtask

    task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_flit(input string name, input flit_t exp, input flit_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input credit_count_t exp,
                               input credit_count_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            report_failure();
        end
    endtask

    // One clock of the link model, the sink stall and the credit gate
    task automatic cycle();
        @(posedge clk);
        fired = src_valid && src_ready;
        if (rst_n && rx_credit) begin
            pend++;
        end
        low_run = (rst_n && !src_ready) ? low_run + 1 : 0;
        if (stall_left > 0 && low_run >= 10) begin
            src_stalled = 1'b1;
        end
        #1;
        snk_ready = (stall_left == 0);
        if (stall_left > 0) begin
            stall_left--;
        end
        if (hold_left == 0 && pend > 0) begin
            tx_credit = 1'b1;
            pend--;
        end else begin
            tx_credit = 1'b0;
        end
        if (hold_left > 0) begin
            hold_left--;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && tx_send) begin
            if (flit_count >= NUM_BEATS * SER_FACTOR) begin
                $display("More flits were sent than the beats account for");
                report_failure();
            end
            check_flit("flit slicing", exp_flits[flit_count], tx_flit);
            flit_count++;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            outstanding = outstanding + int'(tx_send) - int'(tx_credit);
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            if (outstanding > CREDITS) begin
                check_count("credit limit", credit_count_t'(CREDITS),
                            credit_count_t'(outstanding));
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && snk_valid && snk_ready) begin
            if (beat_count >= NUM_BEATS) begin
                $display("A beat arrived after all beats were delivered");
                report_failure();
            end
            check_beat("round trip", stim[beat_count].beat, snk_beat);
            beat_count++;
        end
    end

    initial begin
        int t;
        rst_n = 1'b0;
        src_valid = 1'b0;
        src_beat = '0;
        snk_ready = 1'b1;
        tx_credit = 1'b0;
        void'($urandom(39388));

        // Flit k of a beat carries data bits 16k+15:16k and the beat's destination
        for (int i = 0; i < NUM_BEATS; i++) begin
            stim[i].beat.data = {$urandom, $urandom};
            stim[i].beat.dest = dest_t'(i);
            stim[i].beat.last = (i % 3 == 2);
            stim[i].sink_stall = (i == 4) ? 60 : (i == 8) ? 3 : 0;
            stim[i].credit_hold = (i == 1) ? 25 : (i == 9) ? 6 : 0;
            for (int k = 0; k < SER_FACTOR; k++) begin
                exp_flits[i * SER_FACTOR + k].data = stim[i].beat.data[k * FLIT_W +: FLIT_W];
                exp_flits[i * SER_FACTOR + k].dest = stim[i].beat.dest;
                exp_flits[i * SER_FACTOR + k].is_tail =
                    stim[i].beat.last && (k == SER_FACTOR - 1);
            end
        end

        repeat (2) cycle();
        check_bit("reset snk_valid", 1'b0, snk_valid);
        check_bit("reset tx_send", 1'b0, tx_send);
        check_bit("reset rx_credit", 1'b0, rx_credit);
        check_bit("reset src_ready", 1'b1, src_ready);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_BEATS; i++) begin
            // A running stall or hold keeps going until its count runs out
            if (stim[i].sink_stall > stall_left) begin
                stall_left = stim[i].sink_stall;
            end
            if (stim[i].credit_hold > hold_left) begin
                hold_left = stim[i].credit_hold;
            end
            src_beat = stim[i].beat;
            src_valid = 1'b1;
            t = 0;
            do begin
                cycle();
                t++;
            end while (!fired && t < TIMEOUT);
            if (!fired) begin
                timed_out("src_ready");
            end
        end
        src_valid = 1'b0;

        t = 0;
        while (beat_count < NUM_BEATS && t < TIMEOUT) begin
            cycle();
            t++;
        end
        if (beat_count < NUM_BEATS) begin
            timed_out("all beats at the sink");
        end
        repeat (20) cycle();

        if (flit_count != NUM_BEATS * SER_FACTOR) begin
            $display("FAIL flit total expected %0d actual %0d",
                     NUM_BEATS * SER_FACTOR, flit_count);
            report_failure();
        end
        check_count("credit limit peak", credit_count_t'(CREDITS),
                    credit_count_t'(max_outstanding));
        check_count("credits returned", '0, credit_count_t'(outstanding));
        if (!src_stalled) begin
            $display("src_ready never dropped while the sink was stalled");
            report_failure();
        end

        if (uut.injector.assertions.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Assertions on the injector credit counter failed");
            report_failure();
        end
    end

endmodule: noc_axis_endpoint_tb

// File: noc_axis_endpoint.f
src/noc_flit_pkg.sv
src/noc_axis_pkg.sv
src/flit_fifo.sv
src/axis_serializer.sv
src/flit_injector.sv
src/flit_ejector.sv
src/axis_deserializer.sv
src/noc_axis_endpoint.sv
tests/noc_axis_endpoint_sva.sv
tests/noc_axis_endpoint_tb.sv
